//--- tb.f
+incdir+.
lq_pkg.sv
q_classic.sv
q_lane.sv
lane_dispatch.sv
lane_arbiter.sv
lq_apb_regs.sv
lane_queue_top.sv
tb_lane_queue_top.sv

//--- Bender.yml
package:
  name: lane_queue

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lq_pkg.sv
      - q_classic.sv
      - q_lane.sv
      - lane_dispatch.sv
      - lane_arbiter.sv
      - lq_apb_regs.sv
      - lane_queue_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_lane_queue_top.sv

//--- tb_lane_queue_top.sv
// directed testbench for the lane queue subsystem
// drives the input stream and APB, checks the output stream against per-lane reference queues

`include "lq_cfg.svh"

`default_nettype none

module tb_lane_queue_top;

    import lq_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int NUM_LANES      = `LQ_NUM_LANES;
    // upper bound on stream words over all tests
    localparam int WORD_BUDGET    = 24;
    localparam int TIMEOUT_CYCLES = WORD_BUDGET * 20 + 400;

    logic        CLK;
    logic        nRST;

    logic        in_valid;
    lane_data_t  in_data;
    lane_id_t    in_lane;
    logic        in_ready;
    logic        out_valid;
    lane_data_t  out_data;
    lane_id_t    out_lane;
    logic        out_ready;

    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    apb_addr_t   PADDR;
    logic [31:0] PWDATA;
    logic [31:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;

    // reference model, one entry per accepted word not yet seen at the output
    int          exp_lane [$];
    lane_data_t  exp_data [$];
    int          delivered [NUM_LANES];
    int          last_out_lane;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;

    lane_queue_top UUT (
        .CLK       (CLK),
        .nRST      (nRST),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_lane   (in_lane),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_lane  (out_lane),
        .out_ready (out_ready),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .PWRITE    (PWRITE),
        .PADDR     (PADDR),
        .PWDATA    (PWDATA),
        .PRDATA    (PRDATA),
        .PREADY    (PREADY),
        .PSLVERR   (PSLVERR)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ------------------------------------------------------------------------
    // helpers

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    function automatic int pending_count(input int lane);
        int n;
        n = 0;
        foreach (exp_lane[i]) begin
            if (exp_lane[i] == lane) begin
                n++;
            end
        end
        return n;
    endfunction

    // first lane after last with words waiting, -1 if none
    function automatic int next_rr_lane(input int last);
        int l;
        for (int i = 1; i <= NUM_LANES; i++) begin
            l = (last + i) % NUM_LANES;
            if (pending_count(l) > 0) begin
                return l;
            end
        end
        return -1;
    endfunction

    // ------------------------------------------------------------------------
    // APB

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b1;
        PADDR   = addr;
        PWDATA  = data;
        @(posedge CLK);
        #1;
        PENABLE = 1'b1;
        @(posedge CLK);
        #1;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data,
                            output logic err);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = addr;
        @(posedge CLK);
        #1;
        PENABLE = 1'b1;
        // access phase, sample mid-cycle
        @(negedge CLK);
        data = PRDATA;
        err  = PSLVERR;
        if (PREADY !== 1'b1) begin
            flag_error("PREADY low in an APB access phase");
        end
        @(posedge CLK);
        #1;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // stream

    task automatic drive_word(input int lane, input lane_data_t data);
        in_valid = 1'b1;
        in_lane  = lane_id_t'(lane);
        in_data  = data;
    endtask

    // wait for the handshake, max_cycles 0 means no limit
    task automatic wait_accept(input int max_cycles, output bit accepted);
        int n;
        n        = 0;
        accepted = 1'b0;
        while (!accepted && (max_cycles == 0 || n < max_cycles)) begin
            @(negedge CLK);
            if (in_ready) begin
                @(posedge CLK);
                #1;
                exp_lane.push_back(int'(in_lane));
                exp_data.push_back(in_data);
                in_valid = 1'b0;
                accepted = 1'b1;
            end
            n++;
        end
        if (!accepted) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic send_word(input int lane, input lane_data_t data);
        bit ok;
        drive_word(lane, data);
        wait_accept(0, ok);
    endtask

    // take one output word and match it to the oldest pending word of its lane
    task automatic expect_word(input string name, output int lane);
        lane_data_t data;
        int         idx;
        out_ready = 1'b1;
        @(negedge CLK);
        while (!out_valid) begin
            @(negedge CLK);
        end
        lane = int'(out_lane);
        data = out_data;
        @(posedge CLK);
        #1;
        out_ready = 1'b0;
        idx = -1;
        foreach (exp_lane[i]) begin
            if (idx < 0 && exp_lane[i] == lane) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            flag_error($sformatf("%s: word on lane %0d that was never sent", name, lane));
        end else begin
            check(name, exp_data[idx], data);
            exp_lane.delete(idx);
            exp_data.delete(idx);
            delivered[lane]++;
        end
        last_out_lane = lane;
    endtask

    // ------------------------------------------------------------------------
    // tests

    task automatic reset_values_test();
        logic [31:0] rd;
        logic        err;
        // in_ready low after the first edge, high after the second
        @(posedge CLK);
        @(negedge CLK);
        check("reset in_ready edge 1", 0, in_ready);
        check("reset out_valid", 0, out_valid);
        check("reset PSLVERR", 0, PSLVERR);
        check("reset PRDATA", 0, PRDATA);
        @(negedge CLK);
        check("reset in_ready edge 2", 1, in_ready);
        check("reset out_valid", 0, out_valid);
        @(posedge CLK);
        #1;
        apb_read(`LQ_ADDR_LANE_EN, rd, err);
        check("reset LANE_EN", {NUM_LANES{1'b1}}, rd);
        apb_read(`LQ_ADDR_LANE_BUSY, rd, err);
        check("reset LANE_BUSY", 0, rd);
        for (int i = 0; i < NUM_LANES; i++) begin
            apb_read(apb_addr_t'(`LQ_ADDR_DEQ_CNT_BASE + 4 * i), rd, err);
            check("reset DEQ_COUNT", 0, rd);
        end
    endtask

    task automatic single_lane_test();
        int got;
        fork
            for (int n = 0; n < 6; n++) begin
                send_word(2, next_rand());
            end
            for (int n = 0; n < 6; n++) begin
                expect_word("single_lane data", got);
                check("single_lane out_lane", 2, got);
            end
        join
    endtask

    task automatic round_robin_test();
        int counts [NUM_LANES];
        int exp_l;
        int got;
        // lane 3 left empty so the search must skip it
        counts = '{2, 1, 3, 0};
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int n = 0; n < counts[l]; n++) begin
                send_word(l, next_rand());
            end
        end
        // last word reaches its output register two edges after acceptance
        repeat (3) @(posedge CLK);
        #1;
        for (int n = 0; n < 6; n++) begin
            exp_l = next_rr_lane(last_out_lane);
            expect_word("round_robin data", got);
            check("round_robin out_lane", exp_l, got);
        end
    endtask

    task automatic backpressure_test();
        int          accepted;
        int          got;
        bit          ok;
        logic [31:0] rd;
        logic        err;
        accepted = 0;
        ok       = 1'b1;
        out_ready = 1'b0;
        drive_word(0, next_rand());
        // fill until in_ready stays low for three cycles
        while (ok) begin
            wait_accept(3, ok);
            if (ok) begin
                accepted++;
                drive_word(0, next_rand());
            end
        end
        if (accepted == 0) begin
            flag_error("backpressure: no word accepted before in_ready fell");
        end
        apb_read(`LQ_ADDR_LANE_BUSY, rd, err);
        check("backpressure LANE_BUSY lane 0", 1, rd[0]);
        // release, the stalled word goes in as well
        fork
            wait_accept(0, ok);
            for (int n = 0; n < accepted + 1; n++) begin
                expect_word("backpressure data", got);
            end
        join
        if (exp_lane.size() != 0) begin
            flag_error("backpressure: accepted words never came out");
        end
        @(negedge CLK);
        check("backpressure no extra word", 0, out_valid);
        @(posedge CLK);
        #1;
    endtask

    task automatic lane_enable_test();
        bit ok;
        int got;
        apb_write(`LQ_ADDR_LANE_EN, 32'h0000_000d);
        drive_word(1, next_rand());
        wait_accept(8, ok);
        if (ok) begin
            flag_error("lane_enable: word accepted for a disabled lane");
        end
        apb_write(`LQ_ADDR_LANE_EN, 32'h0000_000f);
        wait_accept(0, ok);
        expect_word("lane_enable data", got);
        check("lane_enable out_lane", 1, got);
    endtask

    task automatic counter_test();
        logic [31:0] rd;
        logic        err;
        int          got;
        for (int i = 0; i < NUM_LANES; i++) begin
            apb_read(apb_addr_t'(`LQ_ADDR_DEQ_CNT_BASE + 4 * i), rd, err);
            check("counter DEQ_COUNT", delivered[i], rd);
            check("counter PSLVERR mapped", 0, err);
        end
        // write clears
        apb_write(`LQ_ADDR_DEQ_CNT_BASE, 32'h0);
        apb_read(`LQ_ADDR_DEQ_CNT_BASE, rd, err);
        check("counter cleared", 0, rd);
        send_word(0, next_rand());
        expect_word("counter data", got);
        apb_read(`LQ_ADDR_DEQ_CNT_BASE, rd, err);
        check("counter after clear", 1, rd);
        // hole in the map
        apb_read(8'h08, rd, err);
        check("counter unmapped PSLVERR", 1, err);
    endtask

    // ------------------------------------------------------------------------
    // main sequence

    initial begin
        nRST      = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_lane   = '0;
        out_ready = 1'b0;
        PSEL      = 1'b0;
        PENABLE   = 1'b0;
        PWRITE    = 1'b0;
        PADDR     = '0;
        PWDATA    = '0;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'h79de;
        last_out_lane = NUM_LANES - 1;
        foreach (delivered[i]) begin
            delivered[i] = 0;
        end

        repeat (8) @(posedge CLK);
        #1;
        check("in reset in_ready", 0, in_ready);
        nRST = 1'b1;

        reset_values_test();
        single_lane_test();
        round_robin_test();
        backpressure_test();
        lane_enable_test();
        counter_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lane_queue_top.sv
// top of the lane queue subsystem: dispatcher, lanes, round-robin arbiter, APB registers
// input words carry a lane number, output words come back tagged with theirs

`include "lq_cfg.svh"

`default_nettype none

module lane_queue_top (
    input  logic               CLK,
    input  logic               nRST,

    // input stream
    input  logic               in_valid,
    input  lq_pkg::lane_data_t in_data,
    input  lq_pkg::lane_id_t   in_lane,
    output logic               in_ready,

    // output stream
    output logic               out_valid,
    output lq_pkg::lane_data_t out_data,
    output lq_pkg::lane_id_t   out_lane,
    input  logic               out_ready,

    // APB slave
    input  logic               PSEL,
    input  logic               PENABLE,
    input  logic               PWRITE,
    input  lq_pkg::apb_addr_t  PADDR,
    input  logic [31:0]        PWDATA,
    output logic [31:0]        PRDATA,
    output logic               PREADY,
    output logic               PSLVERR
);

    import lq_pkg::*;

    // dispatcher <-> lanes
    lane_mask_t enq_valid;
    lane_data_t enq_data;
    lane_mask_t enq_ready;

    // lanes <-> arbiter
    lane_mask_t deq_valid;
    lane_data_t deq_data [`LQ_NUM_LANES];
    lane_mask_t deq_ready;

    // status and control
    lane_mask_t lane_en;
    lane_mask_t lane_busy;
    lane_mask_t grant_pulse;

    // ------------------------------------------------------------------------
    // input side

    lane_dispatch u_dispatch (
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_lane   (in_lane),
        .in_ready  (in_ready),
        .lane_en   (lane_en),
        .enq_valid (enq_valid),
        .enq_data  (enq_data),
        .enq_ready (enq_ready)
    );

    // ------------------------------------------------------------------------
    // lanes

    for (genvar i = 0; i < `LQ_NUM_LANES; i++) begin : g_lane
        q_lane u_lane (
            .CLK       (CLK),
            .nRST      (nRST),
            .enq_valid (enq_valid[i]),
            .enq_data  (enq_data),
            .enq_ready (enq_ready[i]),
            .deq_valid (deq_valid[i]),
            .deq_data  (deq_data[i]),
            .deq_ready (deq_ready[i]),
            .busy      (lane_busy[i])
        );
    end

    // ------------------------------------------------------------------------
    // output side and registers

    lane_arbiter u_arbiter (
        .CLK         (CLK),
        .nRST        (nRST),
        .deq_valid   (deq_valid),
        .deq_data    (deq_data),
        .deq_ready   (deq_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_lane    (out_lane),
        .out_ready   (out_ready),
        .grant_pulse (grant_pulse)
    );

    lq_apb_regs u_regs (
        .CLK         (CLK),
        .nRST        (nRST),
        .PSEL        (PSEL),
        .PENABLE     (PENABLE),
        .PWRITE      (PWRITE),
        .PADDR       (PADDR),
        .PWDATA      (PWDATA),
        .PRDATA      (PRDATA),
        .PREADY      (PREADY),
        .PSLVERR     (PSLVERR),
        .lane_en     (lane_en),
        .lane_busy   (lane_busy),
        .grant_pulse (grant_pulse)
    );

endmodule

`default_nettype wire

//--- lq_apb_regs.sv
// APB slave: lane enables, lane busy status and per-lane dequeue counters
// zero wait states, reads have no side effects, counter writes clear

`include "lq_cfg.svh"

`default_nettype none

module lq_apb_regs (
    input  logic               CLK,
    input  logic               nRST,

    // APB slave
    input  logic               PSEL,
    input  logic               PENABLE,
    input  logic               PWRITE,
    input  lq_pkg::apb_addr_t  PADDR,
    input  logic [31:0]        PWDATA,
    output logic [31:0]        PRDATA,
    output logic               PREADY,
    output logic               PSLVERR,

    // to / from the datapath
    output lq_pkg::lane_mask_t lane_en,
    input  lq_pkg::lane_mask_t lane_busy,
    input  lq_pkg::lane_mask_t grant_pulse
);

    import lq_pkg::*;

    localparam int NUM_LANES = `LQ_NUM_LANES;

    deq_cnt_t    deq_cnt [NUM_LANES];

    logic        access;
    logic        wr_en;
    logic        hit_en;
    logic        hit_busy;
    lane_mask_t  hit_cnt;
    logic        mapped;
    logic [31:0] rd_mux;

    // ------------------------------------------------------------------------
    // address decode

    assign access = PSEL & PENABLE;
    assign wr_en  = access & PWRITE;

    assign hit_en   = (PADDR == `LQ_ADDR_LANE_EN);
    assign hit_busy = (PADDR == `LQ_ADDR_LANE_BUSY);

    // counters at base + 4*i
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            hit_cnt[i] = (PADDR == apb_addr_t'(`LQ_ADDR_DEQ_CNT_BASE + 4 * i));
        end
    end

    assign mapped = hit_en | hit_busy | (|hit_cnt);

    // ------------------------------------------------------------------------
    // read path, valid in the access phase

    always_comb begin
        rd_mux = '0;
        if (hit_en) begin
            rd_mux = 32'(lane_en);
        end
        if (hit_busy) begin
            rd_mux = 32'(lane_busy);
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (hit_cnt[i]) begin
                rd_mux = 32'(deq_cnt[i]);
            end
        end
    end

    assign PRDATA  = (access && !PWRITE) ? rd_mux : '0;
    assign PREADY  = 1'b1;
    assign PSLVERR = access & ~mapped;

    // ------------------------------------------------------------------------
    // registers, write lands at the end of the access phase

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            // all lanes on out of reset
            lane_en <= '1;
            for (int i = 0; i < NUM_LANES; i++) begin
                deq_cnt[i] <= '0;
            end
        end else begin
            if (wr_en && hit_en) begin
                lane_en <= PWDATA[NUM_LANES-1:0];
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                // clear wins over a same-cycle count
                if (wr_en && hit_cnt[i]) begin
                    deq_cnt[i] <= '0;
                end else if (grant_pulse[i] && (deq_cnt[i] != '1)) begin
                    deq_cnt[i] <= deq_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- lane_arbiter.sv
// round-robin merge of the lane outputs into one tagged stream
// selection is combinational from registered state, so no cycle is added

`include "lq_cfg.svh"

`default_nettype none

module lane_arbiter (
    input  logic               CLK,
    input  logic               nRST,

    // from the lanes
    input  lq_pkg::lane_mask_t deq_valid,
    input  lq_pkg::lane_data_t deq_data [`LQ_NUM_LANES],
    output lq_pkg::lane_mask_t deq_ready,

    // merged output stream
    output logic               out_valid,
    output lq_pkg::lane_data_t out_data,
    output lq_pkg::lane_id_t   out_lane,
    input  logic               out_ready,

    // lane transferred this cycle
    output lq_pkg::lane_mask_t grant_pulse
);

    import lq_pkg::*;

    localparam int NUM_LANES = `LQ_NUM_LANES;

    // last lane granted, search starts after it
    lane_id_t last_q;
    // offer pending but not taken, keep the same lane
    logic     hold_q;
    lane_id_t hold_lane_q;

    lane_id_t sel;
    lane_id_t cand;
    logic     found;

    // ------------------------------------------------------------------------
    // selection

    always_comb begin
        sel   = last_q;
        cand  = last_q;
        found = 1'b0;
        if (hold_q) begin
            // output must stay stable until taken
            sel   = hold_lane_q;
            found = deq_valid[hold_lane_q];
        end else begin
            for (int i = 1; i <= NUM_LANES; i++) begin
                cand = lane_id_t'((int'(last_q) + i) % NUM_LANES);
                if (!found && deq_valid[cand]) begin
                    sel   = cand;
                    found = 1'b1;
                end
            end
        end
    end

    assign out_valid = found;
    assign out_lane  = sel;
    assign out_data  = deq_data[sel];

    // only the selected lane sees ready
    always_comb begin
        deq_ready = '0;
        if (found && out_ready) begin
            deq_ready[sel] = 1'b1;
        end
    end

    assign grant_pulse = deq_ready & deq_valid;

    // ------------------------------------------------------------------------
    // pointer and hold state

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            // lane 0 first after reset
            last_q      <= lane_id_t'(NUM_LANES - 1);
            hold_q      <= 1'b0;
            hold_lane_q <= '0;
        end else begin
            // advance only on a transfer
            if (found && out_ready) begin
                last_q <= sel;
            end
            hold_q      <= found & ~out_ready;
            hold_lane_q <= sel;
        end
    end

endmodule

`default_nettype wire

//--- lane_dispatch.sv
// steers the input stream to the lane given by in_lane
// a disabled lane holds off the input instead of dropping the word

`default_nettype none

module lane_dispatch (
    // input stream
    input  logic               in_valid,
    input  lq_pkg::lane_data_t in_data,
    input  lq_pkg::lane_id_t   in_lane,
    output logic               in_ready,

    // per-lane enable from the register block
    input  lq_pkg::lane_mask_t lane_en,

    // to the lanes
    output lq_pkg::lane_mask_t enq_valid,
    output lq_pkg::lane_data_t enq_data,
    input  lq_pkg::lane_mask_t enq_ready
);

    import lq_pkg::*;

    // one-hot decode of the target lane
    lane_mask_t lane_hit;
    // target lane and enabled
    lane_mask_t lane_sel;

    // ------------------------------------------------------------------------
    // decode

    always_comb begin
        lane_hit = '0;
        lane_hit[in_lane] = 1'b1;
    end

    assign lane_sel = lane_hit & lane_en;

    // valid only reaches an enabled lane, so a lane never
    // captures a word the input side thinks is still pending
    assign enq_valid = in_valid ? lane_sel : '0;

    // data is shared, the valid picks the lane
    assign enq_data = in_data;

    // ready from state only, not from in_valid
    assign in_ready = |(lane_sel & enq_ready);

endmodule

`default_nettype wire

//--- q_lane.sv
// one lane: q_classic between an input register and a one-entry output register
// enq_ready is registered and already accounts for the word held at the input

`include "lq_cfg.svh"

`default_nettype none

module q_lane (
    input  logic               CLK,
    input  logic               nRST,

    // enqueue from the dispatcher
    input  logic               enq_valid,
    input  lq_pkg::lane_data_t enq_data,
    output logic               enq_ready,

    // dequeue to the arbiter
    output logic               deq_valid,
    output lq_pkg::lane_data_t deq_data,
    input  logic               deq_ready,

    // any word held anywhere in the lane
    output logic               busy
);

    import lq_pkg::*;

    // input register
    logic       in_valid_q;
    lane_data_t in_data_q;
    // low for the first cycle after reset release
    logic       arm_q;

    // queue side
    logic       q_enq_ready;
    logic       q_almost_full;
    logic       q_deq_valid;
    lane_data_t q_deq_data;
    logic       q_deq_ready;

    logic       accept;
    logic       q_write;
    logic       q_read;
    logic       ready_d;

    q_classic #(
        .NUM_ENTRIES (`LQ_QUEUE_DEPTH)
    ) u_queue (
        .CLK         (CLK),
        .nRST        (nRST),
        .enq_valid   (in_valid_q),
        .enq_data    (in_data_q),
        .enq_ready   (q_enq_ready),
        .almost_full (q_almost_full),
        .deq_valid   (q_deq_valid),
        .deq_data    (q_deq_data),
        .deq_ready   (q_deq_ready)
    );

    assign accept  = enq_valid & enq_ready;
    assign q_write = in_valid_q & q_enq_ready;
    assign q_read  = q_deq_valid & q_deq_ready;

    // output register takes a word when empty or being drained
    assign q_deq_ready = ~deq_valid | deq_ready;

    // next ready: not almost full, and no overfill when the held word,
    // a new accept and a stalled queue all line up
    assign ready_d = arm_q & ~q_almost_full & ~(q_write & ~q_read & accept);

    assign busy = in_valid_q | q_deq_valid | deq_valid;

    // ------------------------------------------------------------------------
    // boundary registers, control

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            in_valid_q <= 1'b0;
            arm_q      <= 1'b0;
            enq_ready  <= 1'b0;
            deq_valid  <= 1'b0;
        end else begin
            in_valid_q <= accept;
            arm_q      <= 1'b1;
            enq_ready  <= ready_d;
            if (q_deq_ready) begin
                deq_valid <= q_deq_valid;
            end
        end
    end

    // payload registers
    always_ff @(posedge CLK) begin
        if (accept) begin
            in_data_q <= enq_data;
        end
        if (q_read) begin
            deq_data <= q_deq_data;
        end
    end

endmodule

`default_nettype wire

//--- q_classic.sv
// circular-buffer queue with valid/ready on both sides
// also reports almost-full so a wrapper can register its ready one cycle early

`default_nettype none

module q_classic #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic               CLK,
    input  logic               nRST,

    // enqueue side
    input  logic               enq_valid,
    input  lq_pkg::lane_data_t enq_data,
    output logic               enq_ready,
    output logic               almost_full,

    // dequeue side
    output logic               deq_valid,
    output lq_pkg::lane_data_t deq_data,
    input  logic               deq_ready
);

    import lq_pkg::*;

    localparam int LOG_NUM_ENTRIES = $clog2(NUM_ENTRIES);

    // extra msb is the wrap bit
    typedef logic [LOG_NUM_ENTRIES:0] ptr_t;

    // storage, no reset needed on payload
    lane_data_t mem [NUM_ENTRIES];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    ptr_t count;
    logic full;
    logic empty;
    logic enq_fire;
    logic deq_fire;

    // ------------------------------------------------------------------------
    // status

    // same index, different wrap bit -> full
    assign full  = (wr_ptr[LOG_NUM_ENTRIES] != rd_ptr[LOG_NUM_ENTRIES]) &&
                   (wr_ptr[LOG_NUM_ENTRIES-1:0] == rd_ptr[LOG_NUM_ENTRIES-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    // occupancy, wraps correctly thanks to the extra bit
    assign count = wr_ptr - rd_ptr;

    assign enq_ready   = ~full;
    assign deq_valid   = ~empty;
    // at most one free place left
    assign almost_full = (count >= ptr_t'(NUM_ENTRIES - 1));

    assign enq_fire = enq_valid & enq_ready;
    assign deq_fire = deq_valid & deq_ready;

    // head of queue straight from the array
    assign deq_data = mem[rd_ptr[LOG_NUM_ENTRIES-1:0]];

    // ------------------------------------------------------------------------
    // pointers

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // array write
    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            mem[wr_ptr[LOG_NUM_ENTRIES-1:0]] <= enq_data;
        end
    end

endmodule

`default_nettype wire

//--- lq_pkg.sv
// shared types for the lane queue subsystem
// modules import this inside their body and use scoped names in port lists

`include "lq_cfg.svh"

`default_nettype none

package lq_pkg;

    // ------------------------------------------------------------------------
    // stream types

    // payload word carried by every queue
    typedef logic [`LQ_DATA_WIDTH-1:0] lane_data_t;

    // lane number tagged on input and output words
    typedef logic [$clog2(`LQ_NUM_LANES)-1:0] lane_id_t;

    // one bit per lane, enables / busy / grants
    typedef logic [`LQ_NUM_LANES-1:0] lane_mask_t;

    // ------------------------------------------------------------------------
    // register block types

    // per-lane dequeue counter, saturating
    typedef logic [`LQ_CNT_WIDTH-1:0] deq_cnt_t;

    // byte address on the APB port
    typedef logic [7:0] apb_addr_t;

endpackage

`default_nettype wire

//--- lq_cfg.svh
// build-time configuration for the lane queue subsystem
// included by the package and by every module that sizes loops or decodes APB addresses

`ifndef LQ_CFG_SVH
`define LQ_CFG_SVH

// lane count and per-lane queue depth
`define LQ_NUM_LANES        4
`define LQ_QUEUE_DEPTH      4

// payload and counter widths
`define LQ_DATA_WIDTH       32
`define LQ_CNT_WIDTH        16

// APB register offsets
`define LQ_ADDR_LANE_EN       8'h00
`define LQ_ADDR_LANE_BUSY     8'h04
// counter for lane i at base + 4*i
`define LQ_ADDR_DEQ_CNT_BASE  8'h10

`endif
